/* common/cam_flash_pkg.sv */
//**************************************************************************
// Widths and sizes assume a 24-bit PP3 flash and 2592-byte image lines
// Commands reach the flash engine as one packed command word
//**************************************************************************
`default_nettype none

package cam_flash_pkg;

  // Host byte that hands the flash to the FPGA
  localparam logic [7:0] take_picture_cmd = 8'hFF;

  // Page geometry, one line is five full pages and one short page
  localparam int page_bytes      = 512;
  localparam int line_pages      = 6;
  localparam int last_page_bytes = 32;

  // Command field widths
  localparam int addr_w = 24;
  localparam int len_w  = 10;

  // Pixel buffer size and occupancy width
  localparam int fifo_depth = 1024;
  localparam int fifo_cnt_w = 11;

  // Guard time before the first status read
  localparam int status_settle_cycles = 256;

  // Status register 1 bits
  localparam int sr1_wip_bit = 0;
  localparam int sr1_wel_bit = 1;

  typedef enum logic [1:0] {
    op_rdsr1,
    op_wren,
    op_pp3
  } flash_op_e;

  typedef enum logic [3:0] {
    idle,
    settle,
    poll_ready,
    wait_image,
    wren,
    wren_check,
    fill_wait,
    page_prog,
    prog_check,
    next_page
  } seq_state_e;

  // One command for the external flash engine
  typedef struct packed {
    flash_op_e           op;
    logic [addr_w-1:0]   address;
    logic [len_w-1:0]    num_bytes;
  } flash_cmd_t;

  // Camera byte with frame marks
  typedef struct packed {
    logic       valid;
    logic       first;
    logic       last;
    logic [7:0] data;
  } pixel_byte_t;

endpackage

`default_nettype wire

/* rtl/pixel_fifo.sv */
//**************************************************************************
// No back-pressure toward the camera, bytes arriving while full are dropped
// Head byte is shown ahead and moves on the edge after byte_take
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

module pixel_fifo import cam_flash_pkg::*; (
  input  logic                  flash_mem_interface_done,
  input  logic                  reset_PP3_command_counter,
  input  pixel_byte_t           pixel_in,
  input  logic                  byte_take,
  input  logic                  clear_flags,
  output logic [7:0]            flash_byte,
  output logic [fifo_cnt_w-1:0] fifo_count,
  output logic                  empty,
  output logic                  image_started,
  output logic                  image_finished,
  output logic                  fifo_overflow
);

  logic [7:0]                    mem [fifo_depth];
  logic [$clog2(fifo_depth)-1:0] wr_ptr;
  logic [$clog2(fifo_depth)-1:0] rd_ptr;
  logic                          full;
  logic                          do_write;
  logic                          do_read;

  assign full     = fifo_count == fifo_cnt_w'(fifo_depth);
  assign empty    = fifo_count == '0;
  assign do_write = pixel_in.valid && !full;
  // A take on an empty buffer is ignored
  assign do_read  = byte_take && !empty;

  // Show-ahead head byte
  assign flash_byte = mem[rd_ptr];

  always_ff @(posedge flash_mem_interface_done) begin
    if (do_write) begin
      mem[wr_ptr] <= pixel_in.data;
    end
  end

  always_ff @(posedge flash_mem_interface_done or posedge reset_PP3_command_counter) begin
    if (reset_PP3_command_counter) begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      fifo_count     <= '0;
      image_started  <= 1'b0;
      image_finished <= 1'b0;
      fifo_overflow  <= 1'b0;
    end else begin
      // Pointers wrap naturally at the power-of-two depth
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_write, do_read})
        2'b10:   fifo_count <= fifo_count + 1'b1;
        2'b01:   fifo_count <= fifo_count - 1'b1;
        default: fifo_count <= fifo_count;
      endcase
      // Trigger clears the marks, a mark in the same cycle still wins
      if (clear_flags) begin
        image_started  <= 1'b0;
        image_finished <= 1'b0;
        fifo_overflow  <= 1'b0;
      end
      if (pixel_in.valid && pixel_in.first) begin
        image_started <= 1'b1;
      end
      if (pixel_in.valid && pixel_in.last) begin
        image_finished <= 1'b1;
      end
      // Sticky until next trigger
      if (pixel_in.valid && full) begin
        fifo_overflow <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/page_planner.sv */
//**************************************************************************
// Pages stride by page_bytes from address 0, six pages per image line
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

module page_planner import cam_flash_pkg::*; (
  input  logic              flash_mem_interface_done,
  input  logic              reset_PP3_command_counter,
  input  logic              start_image,
  input  logic              advance,
  output logic [addr_w-1:0] page_addr,
  output logic [len_w-1:0]  page_len
);

  // Page position inside the current line
  logic [$clog2(line_pages)-1:0] page_idx;
  logic                          last_in_line;

  assign last_in_line = int'(page_idx) == line_pages - 1;

  // Sixth page only tops up the line
  assign page_len = last_in_line ? len_w'(last_page_bytes) : len_w'(page_bytes);

  always_ff @(posedge flash_mem_interface_done or posedge reset_PP3_command_counter) begin
    if (reset_PP3_command_counter) begin
      page_addr <= '0;
      page_idx  <= '0;
    end else if (start_image) begin
      // New image restarts at the bottom of the flash
      page_addr <= '0;
      page_idx  <= '0;
    end else if (advance) begin
      // Short page still takes a full stride
      page_addr <= page_addr + addr_w'(page_bytes);
      if (last_in_line) begin
        page_idx <= '0;
      end else begin
        page_idx <= page_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* flash_seq/flash_cmd_port.sv */
//**************************************************************************
// Four-phase req/ack, a new req waits until ack has been seen low
// Issue while busy is ignored
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

module flash_cmd_port import cam_flash_pkg::*; (
  input  logic              flash_mem_interface_done,
  input  logic              reset_PP3_command_counter,
  input  logic              issue,
  input  flash_op_e         issue_op,
  input  logic [addr_w-1:0] issue_addr,
  input  logic [len_w-1:0]  issue_len,
  output logic              busy,
  output logic              done,
  output logic [7:0]        status,
  output flash_cmd_t        cmd,
  output logic              cmd_req,
  input  logic              cmd_ack,
  input  logic [7:0]        status_byte
);

  logic start;
  logic finish;

  assign start  = issue && !busy;
  assign finish = cmd_req && cmd_ack;

  // Command word held stable for the whole request
  always_ff @(posedge flash_mem_interface_done) begin
    if (start) begin
      cmd <= '{op: issue_op, address: issue_addr, num_bytes: issue_len};
    end
    // Status byte is only valid with ack of a status read
    if (finish && cmd.op == op_rdsr1) begin
      status <= status_byte;
    end
  end

  always_ff @(posedge flash_mem_interface_done or posedge reset_PP3_command_counter) begin
    if (reset_PP3_command_counter) begin
      cmd_req <= 1'b0;
      busy    <= 1'b0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        cmd_req <= 1'b1;
        busy    <= 1'b1;
      end else if (finish) begin
        cmd_req <= 1'b0;
        done    <= 1'b1;
      end else if (busy && !cmd_req && !cmd_ack) begin
        // Engine has dropped ack, port free again
        busy <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* flash_seq/flash_write_sequencer.sv */
//**************************************************************************
// Issue waits for the command port to be idle, so a slow engine stalls here
// Status is only sampled on the done pulse of a status read
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

module flash_write_sequencer import cam_flash_pkg::*; (
  input  logic                  flash_mem_interface_done,
  input  logic                  reset_PP3_command_counter,
  input  logic [7:0]            host_byte,
  input  logic                  host_byte_valid,
  input  logic [fifo_cnt_w-1:0] fifo_count,
  input  logic                  empty,
  input  logic                  image_started,
  input  logic                  image_finished,
  input  logic [len_w-1:0]      page_len,
  input  logic [addr_w-1:0]     page_addr,
  input  logic                  port_busy,
  input  logic                  port_done,
  input  logic [7:0]            port_status,
  output logic                  issue,
  output flash_op_e             issue_op,
  output logic [len_w-1:0]      issue_len,
  output logic [addr_w-1:0]     issue_addr,
  output logic                  start_image,
  output logic                  advance,
  output logic                  clear_flags,
  output logic                  fpga_owns_flash
);

  seq_state_e                            state;
  logic [$clog2(status_settle_cycles):0] settle_cnt;
  logic                                  sent;
  logic [len_w-1:0]                      pp_len;
  logic                                  trigger;
  logic                                  cmd_state;
  logic                                  drained;
  logic                                  page_ready;

  assign trigger    = state == idle && host_byte_valid && host_byte == take_picture_cmd;
  // Nothing left to write for this image
  assign drained    = image_finished && empty;
  assign page_ready = fifo_count >= fifo_cnt_w'(page_len);
  assign cmd_state  = state inside {poll_ready, wren, wren_check, page_prog, prog_check};

  // One pulse per command state visit, resent after a failed status check
  assign issue = cmd_state && !sent && !port_busy;

  always_comb begin
    case (state)
      wren:      issue_op = op_wren;
      page_prog: issue_op = op_pp3;
      default:   issue_op = op_rdsr1;
    endcase
  end

  // Address and length only matter for PP3
  assign issue_len  = (state == page_prog) ? pp_len : '0;
  assign issue_addr = (state == page_prog) ? page_addr : '0;

  assign start_image     = trigger;
  assign clear_flags     = trigger;
  assign advance         = state == next_page && !drained;
  assign fpga_owns_flash = state != idle;

  always_ff @(posedge flash_mem_interface_done or posedge reset_PP3_command_counter) begin
    if (reset_PP3_command_counter) begin
      state      <= idle;
      settle_cnt <= '0;
      sent       <= 1'b0;
      pp_len     <= '0;
    end else begin
      if (issue) begin
        sent <= 1'b1;
      end else if (port_done) begin
        sent <= 1'b0;
      end
      case (state)
        idle: begin
          if (trigger) begin
            settle_cnt <= '0;
            state      <= settle;
          end
        end
        // Let any host write in flight finish before polling
        settle: begin
          if (int'(settle_cnt) == status_settle_cycles) begin
            state <= poll_ready;
          end else begin
            settle_cnt <= settle_cnt + 1'b1;
          end
        end
        poll_ready: begin
          if (port_done && !port_status[sr1_wip_bit]) begin
            state <= wait_image;
          end
        end
        wait_image: begin
          if (image_started) begin
            state <= wren;
          end
        end
        wren: begin
          if (port_done) begin
            state <= wren_check;
          end
        end
        // Repeat until the write enable latch reads back set
        wren_check: begin
          if (port_done && port_status[sr1_wel_bit]) begin
            state <= fill_wait;
          end
        end
        fill_wait: begin
          if (drained) begin
            state <= prog_check;
          end else if (page_ready) begin
            pp_len <= page_len;
            state  <= page_prog;
          end else if (image_finished) begin
            // Tail of the image, flush what is left
            pp_len <= len_w'(fifo_count);
            state  <= page_prog;
          end
        end
        page_prog: begin
          if (port_done) begin
            state <= prog_check;
          end
        end
        prog_check: begin
          if (port_done && !port_status[sr1_wip_bit]) begin
            state <= next_page;
          end
        end
        next_page: begin
          if (drained) begin
            state <= idle;
          end else begin
            state <= wren;
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/cam_flash_top.sv */
//**************************************************************************
// Flash pins and the host SPI sit outside, behind the command and byte ports
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

module cam_flash_top import cam_flash_pkg::*; (
  input  logic        flash_mem_interface_done,
  input  logic        reset_PP3_command_counter,
  input  logic [7:0]  host_byte,
  input  logic        host_byte_valid,
  input  pixel_byte_t pixel_in,
  output flash_cmd_t  cmd,
  output logic        cmd_req,
  input  logic        cmd_ack,
  input  logic [7:0]  status_byte,
  input  logic        byte_take,
  output logic [7:0]  flash_byte,
  output logic        fpga_owns_flash,
  output logic        fifo_overflow
);

  logic [fifo_cnt_w-1:0] fifo_count;
  logic                  empty;
  logic                  image_started;
  logic                  image_finished;
  logic                  clear_flags;
  logic                  start_image;
  logic                  advance;
  logic [addr_w-1:0]     page_addr;
  logic [len_w-1:0]      page_len;
  logic                  issue;
  flash_op_e             issue_op;
  logic [addr_w-1:0]     issue_addr;
  logic [len_w-1:0]      issue_len;
  logic                  port_busy;
  logic                  port_done;
  logic [7:0]            port_status;

  // Camera bytes toward PP3 data
  pixel_fifo i_pixel_fifo (
    .flash_mem_interface_done (flash_mem_interface_done),
    .reset_PP3_command_counter(reset_PP3_command_counter),
    .pixel_in                 (pixel_in),
    .byte_take                (byte_take),
    .clear_flags              (clear_flags),
    .flash_byte               (flash_byte),
    .fifo_count               (fifo_count),
    .empty                    (empty),
    .image_started            (image_started),
    .image_finished           (image_finished),
    .fifo_overflow            (fifo_overflow)
  );

  page_planner i_page_planner (
    .flash_mem_interface_done (flash_mem_interface_done),
    .reset_PP3_command_counter(reset_PP3_command_counter),
    .start_image              (start_image),
    .advance                  (advance),
    .page_addr                (page_addr),
    .page_len                 (page_len)
  );

  flash_write_sequencer i_flash_write_sequencer (
    .flash_mem_interface_done (flash_mem_interface_done),
    .reset_PP3_command_counter(reset_PP3_command_counter),
    .host_byte                (host_byte),
    .host_byte_valid          (host_byte_valid),
    .fifo_count               (fifo_count),
    .empty                    (empty),
    .image_started            (image_started),
    .image_finished           (image_finished),
    .page_len                 (page_len),
    .page_addr                (page_addr),
    .port_busy                (port_busy),
    .port_done                (port_done),
    .port_status              (port_status),
    .issue                    (issue),
    .issue_op                 (issue_op),
    .issue_len                (issue_len),
    .issue_addr               (issue_addr),
    .start_image              (start_image),
    .advance                  (advance),
    .clear_flags              (clear_flags),
    .fpga_owns_flash          (fpga_owns_flash)
  );

  // Handshake toward the external flash engine
  flash_cmd_port i_flash_cmd_port (
    .flash_mem_interface_done (flash_mem_interface_done),
    .reset_PP3_command_counter(reset_PP3_command_counter),
    .issue                    (issue),
    .issue_op                 (issue_op),
    .issue_addr               (issue_addr),
    .issue_len                (issue_len),
    .busy                     (port_busy),
    .done                     (port_done),
    .status                   (port_status),
    .cmd                      (cmd),
    .cmd_req                  (cmd_req),
    .cmd_ack                  (cmd_ack),
    .status_byte              (status_byte)
  );

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
//**************************************************************************
// 40 ns clock, reset held high for the first 4 rising edges
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic flash_mem_interface_done,
  output logic reset_PP3_command_counter
);

  // Half of the 40 ns period
  localparam int half_period = 20;

  initial begin
    flash_mem_interface_done = 1'b0;
    forever #(half_period) flash_mem_interface_done = ~flash_mem_interface_done;
  end

  // Release just after an edge, like the other stimulus
  initial begin
    reset_PP3_command_counter = 1'b1;
    repeat (4) @(posedge flash_mem_interface_done);
    #2;
    reset_PP3_command_counter = 1'b0;
  end

endmodule

`default_nettype wire

/* verif/cam_flash_tb.sv */
//**************************************************************************
// Two images of 2 lines plus 700 bytes against a flash engine model with
// random ack latency, status bits and byte_take gaps. Image memory is 8 KB
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

module cam_flash_tb import cam_flash_pkg::*; ();

  localparam logic [31:0] rng_seed = 32'hb411_c004;
  localparam int line_bytes = (line_pages - 1) * page_bytes + last_page_bytes;
  localparam int tail_bytes = 700;
  localparam int img_len = 2 * line_bytes + tail_bytes;
  localparam int num_images = 2;
  localparam int pages_per_image = 2 * line_pages + (tail_bytes + page_bytes - 1) / page_bytes;
  // 40 cycles per image byte plus 2000 per page
  localparam int timeout_cycles = num_images * (40 * img_len + 2000 * pages_per_image);
  localparam int mem_size = 8192;

  logic        flash_mem_interface_done;
  logic        reset_PP3_command_counter;
  logic [7:0]  host_byte;
  logic        host_byte_valid;
  pixel_byte_t pixel_in;
  flash_cmd_t  cmd;
  logic        cmd_req;
  logic        cmd_ack;
  logic [7:0]  status_byte;
  logic        byte_take;
  logic [7:0]  flash_byte;
  logic        fpga_owns_flash;
  logic        fifo_overflow;

  // Flash image memory and the bytes sent per image
  logic [7:0] flash_mem [mem_size];
  logic [7:0] sent_bytes [num_images][img_len];

  int errors = 0;
  int images_done = 0;
  int images_started = 0;
  int pages_total = 0;
  int pages_done = 0;
  int img_written = 0;
  int cur_img = 0;
  logic [31:0] stim_state = rng_seed;
  logic [31:0] eng_state = rng_seed;

  // Flash status model and command order tracking
  int   wip_left = 0;
  int   wel_left = 0;
  logic wel_set = 1'b0;
  logic wren_done = 1'b0;
  logic wel_confirmed = 1'b0;
  logic wip_pending = 1'b0;
  logic first_cmd_pending = 1'b0;

  // Values seen at the previous falling edge
  logic       prev_req = 1'b0;
  logic       prev_ack = 1'b0;
  logic       prev_owns = 1'b0;
  logic       prev_host_valid = 1'b0;
  logic [7:0] prev_host_byte = 8'h00;
  flash_cmd_t prev_cmd = '0;

  tb_clock_gen i_tb_clock_gen (
    .flash_mem_interface_done (flash_mem_interface_done),
    .reset_PP3_command_counter(reset_PP3_command_counter)
  );

  cam_flash_top i_cam_flash_top (
    .flash_mem_interface_done (flash_mem_interface_done),
    .reset_PP3_command_counter(reset_PP3_command_counter),
    .host_byte                (host_byte),
    .host_byte_valid          (host_byte_valid),
    .pixel_in                 (pixel_in),
    .cmd                      (cmd),
    .cmd_req                  (cmd_req),
    .cmd_ack                  (cmd_ack),
    .status_byte              (status_byte),
    .byte_take                (byte_take),
    .flash_byte               (flash_byte),
    .fpga_owns_flash          (fpga_owns_flash),
    .fifo_overflow            (fifo_overflow)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Flash address of image byte j with six pages per line at a 512 stride
  function automatic int byte_addr(input int j);
    int line_no;
    int offset;
    line_no = j / line_bytes;
    offset  = j % line_bytes;
    return (line_no * line_pages + offset / page_bytes) * page_bytes + offset % page_bytes;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  task automatic next_cycle();
    @(posedge flash_mem_interface_done);
    #2;
  endtask

  task automatic end_run(input logic timed_out);
    $display("Summary: %0d errors, %0d images checked, %0d pages programmed",
             errors, images_done, pages_total);
    if (errors == 0 && !timed_out) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  // One cycle of camera byte plus random host noise that never hits the trigger
  task automatic drive_cycle(input pixel_byte_t px);
    next_cycle();
    pixel_in = px;
    stim_state = xorshift(stim_state);
    host_byte_valid = stim_state[2:0] == 3'd0;
    host_byte = (stim_state[15:8] == take_picture_cmd) ? 8'h3c : stim_state[15:8];
  endtask

  task automatic send_trigger();
    next_cycle();
    pixel_in = '0;
    host_byte = take_picture_cmd;
    host_byte_valid = 1'b1;
  endtask

  // Valid about one cycle in four
  task automatic send_pixel(input int img, input int j);
    pixel_byte_t px;
    logic        done;
    done = 1'b0;
    while (!done) begin
      stim_state = xorshift(stim_state);
      px = '0;
      if (stim_state[1:0] == 2'd0) begin
        px.valid = 1'b1;
        px.first = j == 0;
        px.last  = j == img_len - 1;
        px.data  = stim_state[23:16];
        sent_bytes[img][j] = px.data;
        done = 1'b1;
      end
      drive_cycle(px);
    end
  endtask

  // Ownership rose so the page bookkeeping restarts and memory is refilled
  task automatic begin_image();
    int a;
    cur_img = (images_started < num_images) ? images_started : num_images - 1;
    images_started++;
    img_written = 0;
    pages_done = 0;
    first_cmd_pending = 1'b1;
    for (a = 0; a < mem_size; a++) begin
      flash_mem[a] = 8'(a) ^ 8'(a >> 5) ^ 8'(cur_img);
    end
  endtask

  task automatic check_image();
    int mism;
    int j;
    mism = 0;
    assert (img_written == img_len) else
      report_error($sformatf("image %0d wrote %0d bytes, expected %0d",
                             cur_img, img_written, img_len));
    for (j = 0; j < img_len; j++) begin
      if (flash_mem[byte_addr(j)] != sent_bytes[cur_img][j]) begin
        mism++;
      end
    end
    assert (mism == 0) else
      report_error($sformatf("image %0d has %0d bytes differing from the sent pixels",
                             cur_img, mism));
    images_done++;
  endtask

  // Status register 1 read with wip and wel delays counted per read
  task automatic read_status(output logic [7:0] sr);
    sr = 8'h00;
    if (wip_left > 0) begin
      sr[sr1_wip_bit] = 1'b1;
      wip_left--;
    end
    if (wel_set) begin
      if (wel_left > 0) begin
        wel_left--;
      end else begin
        sr[sr1_wel_bit] = 1'b1;
      end
    end
    if (sr[sr1_wel_bit] && wren_done) begin
      wel_confirmed = 1'b1;
    end
    if (!sr[sr1_wip_bit]) begin
      wip_pending = 1'b0;
    end
  endtask

  task automatic enable_write();
    assert (!wip_pending) else
      report_error("WREN issued before a status read showed wip clear");
    wren_done = 1'b1;
    wel_confirmed = 1'b0;
    wel_set = 1'b1;
    eng_state = xorshift(eng_state);
    wel_left = int'(eng_state % 3);
  endtask

  task automatic program_page(input flash_cmd_t c);
    int rule_len;
    int exp_len;
    int remain;
    int i;
    int a;
    assert (wren_done && wel_confirmed) else
      report_error("PP3 without a WREN and a status read showing wel set");
    // Expected length from the page pattern and cut short at the image end
    rule_len = (pages_done % line_pages == line_pages - 1) ? last_page_bytes : page_bytes;
    remain = img_len - img_written;
    exp_len = (remain < rule_len) ? remain : rule_len;
    assert (int'(c.address) == pages_done * page_bytes) else
      report_error($sformatf("PP3 address %0h, expected %0h",
                             c.address, pages_done * page_bytes));
    assert (int'(c.num_bytes) == exp_len) else
      report_error($sformatf("PP3 length %0d, expected %0d", c.num_bytes, exp_len));
    for (i = 0; i < int'(c.num_bytes); i++) begin
      eng_state = xorshift(eng_state);
      // Occasional gap between takes
      if (eng_state[1:0] == 2'd0) begin
        byte_take = 1'b0;
        next_cycle();
      end
      a = int'(c.address) + i;
      if (a < mem_size) begin
        flash_mem[a] = flash_byte;
      end
      byte_take = 1'b1;
      next_cycle();
    end
    byte_take = 1'b0;
    img_written += int'(c.num_bytes);
    pages_done++;
    pages_total++;
    wip_pending = 1'b1;
    wren_done = 1'b0;
    wel_confirmed = 1'b0;
    wel_set = 1'b0;
    eng_state = xorshift(eng_state);
    wip_left = int'(eng_state % 4);
  endtask

  // Flash engine model that answers each req after a random delay
  initial begin : flash_engine
    flash_cmd_t  c;
    logic [7:0]  sr;
    cmd_ack = 1'b0;
    status_byte = 8'h00;
    byte_take = 1'b0;
    @(negedge reset_PP3_command_counter);
    forever begin
      while (!cmd_req) begin
        next_cycle();
      end
      c = cmd;
      eng_state = xorshift(eng_state);
      repeat (1 + int'(eng_state[2:0])) next_cycle();
      if (first_cmd_pending) begin
        assert (c.op == op_rdsr1) else
          report_error($sformatf("first command after trigger is op %0d", c.op));
        first_cmd_pending = 1'b0;
      end
      assert (c.op inside {op_rdsr1, op_wren, op_pp3}) else
        report_error($sformatf("unknown command op %0d", c.op));
      // Random status byte for commands without a status result
      sr = eng_state[15:8];
      case (c.op)
        op_rdsr1: read_status(sr);
        op_wren:  enable_write();
        op_pp3:   program_page(c);
      endcase
      status_byte = sr;
      cmd_ack = 1'b1;
      while (cmd_req) begin
        next_cycle();
      end
      // Ack lingers a random few cycles after req falls
      eng_state = xorshift(eng_state);
      repeat (int'(eng_state[1:0])) next_cycle();
      cmd_ack = 1'b0;
      next_cycle();
    end
  end

  // Handshake, ownership and overflow checks mid-cycle
  always @(negedge flash_mem_interface_done) begin
    if (!reset_PP3_command_counter) begin
      assert (!fifo_overflow) else report_error("fifo_overflow set");
      if (prev_req && !cmd_req) begin
        assert (prev_ack) else report_error("cmd_req fell before cmd_ack");
      end
      if (!prev_req && cmd_req) begin
        assert (!prev_ack) else report_error("cmd_req rose while cmd_ack was high");
      end
      if (prev_req && cmd_req) begin
        assert (cmd == prev_cmd) else report_error("cmd changed while cmd_req was high");
      end
      if (!prev_owns && fpga_owns_flash) begin
        assert (prev_host_valid && prev_host_byte == take_picture_cmd) else
          report_error("fpga_owns_flash rose without a take-picture byte");
        begin_image();
      end
      if (prev_owns && !fpga_owns_flash) begin
        check_image();
      end
    end
    prev_req = cmd_req;
    prev_ack = cmd_ack;
    prev_owns = fpga_owns_flash;
    prev_host_valid = host_byte_valid;
    prev_host_byte = host_byte;
    prev_cmd = cmd;
  end

  initial begin : watchdog
    int cycle_cnt;
    cycle_cnt = 0;
    while (cycle_cnt < timeout_cycles) begin
      @(posedge flash_mem_interface_done);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
    end_run(1'b1);
  end

  initial begin : stimulus
    int img;
    int j;
    host_byte = 8'h00;
    host_byte_valid = 1'b0;
    pixel_in = '0;
    @(negedge reset_PP3_command_counter);
    assert (!fpga_owns_flash && !cmd_req && !fifo_overflow) else
      report_error("outputs not low after reset");
    for (img = 0; img < num_images; img++) begin
      repeat (20) drive_cycle('0);
      send_trigger();
      while (!fpga_owns_flash) begin
        drive_cycle('0);
      end
      // Camera starts a little after the trigger
      repeat (8) drive_cycle('0);
      for (j = 0; j < img_len; j++) begin
        send_pixel(img, j);
      end
      while (fpga_owns_flash) begin
        drive_cycle('0);
      end
    end
    repeat (20) drive_cycle('0);
    assert (images_done == num_images) else
      report_error($sformatf("%0d images finished, expected %0d", images_done, num_images));
    end_run(1'b0);
  end

endmodule

`default_nettype wire

/* sim.f */
common/cam_flash_pkg.sv
rtl/pixel_fifo.sv
rtl/page_planner.sv
flash_seq/flash_cmd_port.sv
flash_seq/flash_write_sequencer.sv
rtl/cam_flash_top.sv
verif/tb_clock_gen.sv
verif/cam_flash_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, fail if the log reports errors
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module cam_flash_tb \
  -f sim.f -o cam_flash_sim
./obj_dir/cam_flash_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Finished with errors" sim.log; then
  exit 1
fi
exit 0
